// ==== hdl/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath and bus width
`define MIPS_DATA_W 32

// register file geometry
`define MIPS_REG_AW    5
`define MIPS_REG_COUNT 32

// jal writes its link address here
`define MIPS_RA_REG 31

// bytes per instruction
`define MIPS_PC_STEP 4

`endif

// ==== hdl/mips_pkg.sv ====
`default_nettype none
`include "mips_macros.svh"

package mips_pkg;

	typedef logic [`MIPS_DATA_W-1:0] word_t;
	typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		st_init, st_if, st_iw, st_id, st_ex, st_ld, st_rdw, st_st, st_wb
	} cpu_state_e;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		op_rtype = 6'h00, op_j     = 6'h02, op_jal   = 6'h03, op_beq  = 6'h04,
		op_bne   = 6'h05, op_addiu = 6'h09, op_slti  = 6'h0a, op_sltiu = 6'h0b,
		op_andi  = 6'h0c, op_ori   = 6'h0d, op_xori  = 6'h0e, op_lui  = 6'h0f,
		op_lw    = 6'h23, op_sw    = 6'h2b
	} opcode_e;

	// function field of R-type, bits 5:0
	typedef enum logic [5:0] {
		fn_sll  = 6'h00, fn_srl = 6'h02, fn_sra = 6'h03, fn_addu = 6'h21,
		fn_subu = 6'h23, fn_and = 6'h24, fn_or  = 6'h25, fn_xor  = 6'h26,
		fn_nor  = 6'h27, fn_slt = 6'h2a, fn_sltu = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
	} alu_op_e;

	typedef enum logic [1:0] {a_rs, a_pc, a_shamt} a_src_e;
	typedef enum logic [2:0] {b_rt, b_sext, b_zext, b_step, b_boff} b_src_e;

	typedef enum logic [2:0] {
		cls_nop, cls_alu, cls_load, cls_store, cls_branch, cls_jump, cls_link
	} inst_class_e;

	typedef enum logic [1:0] {wb_rd, wb_rt, wb_ra} wb_dest_e;

endpackage

`default_nettype wire

// ==== hdl/mips_regfile.sv ====
`default_nettype none
`include "mips_macros.svh"

module mips_regfile import mips_pkg::*; (
	input  wire             clk,
	input  wire reg_addr_t  raddr1,
	input  wire reg_addr_t  raddr2,
	input  wire reg_addr_t  waddr,
	input  wire             wen,
	input  wire word_t      wdata,
	output word_t           rdata1,
	output word_t           rdata2
);

	word_t regs [`MIPS_REG_COUNT];

	always_ff @(posedge clk) begin
		if (wen && waddr != '0) // writes to r0 are dropped
			regs[waddr] <= wdata;
	end

	// async read, r0 hardwired
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== hdl/mips_alu.sv ====
`default_nettype none

module mips_alu import mips_pkg::*; (
	input  wire word_t   a,
	input  wire word_t   b,
	input  wire alu_op_e op,
	output word_t        result,
	output logic         zero
);

	logic [4:0] shamt;

	// shifts move b by the low bits of a
	assign shamt = a[4:0];

	always_comb begin
		case (op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_nor:  result = ~(a | b);
			alu_slt:  result = word_t'($signed(a) < $signed(b));
			alu_sltu: result = word_t'(a < b);
			alu_sll:  result = b << shamt;
			alu_srl:  result = b >> shamt;
			alu_sra:  result = $signed(b) >>> shamt;
			alu_lui:  result = {b[15:0], 16'h0000}; // b carries the zero-extended imm
			default:  result = a + b;
		endcase
	end

	// beq/bne look at this after a subtract
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== hdl/mips_decoder.sv ====
`default_nettype none

module mips_decoder import mips_pkg::*; (
	input  wire word_t  instr,
	output inst_class_e inst_class,
	output alu_op_e     alu_op,
	output a_src_e      a_src,
	output b_src_e      b_src,
	output wb_dest_e    wb_dest,
	output logic        branch_ne
);

	opcode_e opcode;
	funct_e  funct;

	assign opcode = opcode_e'(instr[31:26]);
	assign funct  = funct_e'(instr[5:0]);

	always_comb begin
		inst_class = cls_nop;
		alu_op     = alu_add;
		a_src      = a_rs;
		b_src      = b_rt;
		wb_dest    = wb_rt;
		branch_ne  = 1'b0;
		if (instr != '0) begin // all-zero word stays a nop
			case (opcode)
				op_rtype: begin
					inst_class = cls_alu;
					wb_dest    = wb_rd;
					case (funct)
						fn_addu: alu_op = alu_add;
						fn_subu: alu_op = alu_sub;
						fn_and:  alu_op = alu_and;
						fn_or:   alu_op = alu_or;
						fn_xor:  alu_op = alu_xor;
						fn_nor:  alu_op = alu_nor;
						fn_slt:  alu_op = alu_slt;
						fn_sltu: alu_op = alu_sltu;
						fn_sll: begin
							alu_op = alu_sll;
							a_src  = a_shamt;
						end
						fn_srl: begin
							alu_op = alu_srl;
							a_src  = a_shamt;
						end
						fn_sra: begin
							alu_op = alu_sra;
							a_src  = a_shamt;
						end
						default: inst_class = cls_nop;
					endcase
				end
				op_addiu: {inst_class, b_src} = {cls_alu, b_sext};
				op_slti:  {inst_class, b_src, alu_op} = {cls_alu, b_sext, alu_slt};
				op_sltiu: {inst_class, b_src, alu_op} = {cls_alu, b_sext, alu_sltu};
				op_andi:  {inst_class, b_src, alu_op} = {cls_alu, b_zext, alu_and};
				op_ori:   {inst_class, b_src, alu_op} = {cls_alu, b_zext, alu_or};
				op_xori:  {inst_class, b_src, alu_op} = {cls_alu, b_zext, alu_xor};
				op_lui:   {inst_class, b_src, alu_op} = {cls_alu, b_zext, alu_lui};
				op_lw:    {inst_class, b_src} = {cls_load, b_sext};  // address = rs + imm
				op_sw:    {inst_class, b_src} = {cls_store, b_sext};
				op_beq, op_bne: begin
					inst_class = cls_branch;
					alu_op     = alu_sub;
					branch_ne  = (opcode == op_bne);
				end
				op_j: inst_class = cls_jump;
				op_jal: begin
					inst_class = cls_link;
					a_src      = a_pc; // pc already +4, one more step gives the link
					b_src      = b_step;
					wb_dest    = wb_ra;
				end
				default: inst_class = cls_nop; // unknown opcode just falls through
			endcase
		end
	end

	a_mem_add: assert final (!(inst_class inside {cls_load, cls_store}) || alu_op == alu_add)
		else $error("load/store decoded without add");

endmodule

`default_nettype wire

// ==== hdl/mips_control_fsm.sv ====
`default_nettype none

module mips_control_fsm import mips_pkg::*; (
	input  wire              clk,
	input  wire              rst,
	input  wire inst_class_e inst_class,
	input  wire              inst_req_ready,
	input  wire              inst_valid,
	input  wire              mem_req_ready,
	input  wire              read_data_valid,
	output cpu_state_e       state,
	output logic             inst_req_valid,
	output logic             inst_ready,
	output logic             mem_read,
	output logic             mem_write,
	output logic             read_data_ready
);

	cpu_state_e next_state;

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_init;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state; // any back-pressure just holds
		case (state)
			st_init: next_state = st_if;
			st_if:   if (inst_req_ready) next_state = st_iw;
			st_iw:   if (inst_valid) next_state = st_id;
			st_id:   next_state = (inst_class == cls_nop) ? st_if : st_ex;
			st_ex: begin
				case (inst_class)
					cls_alu, cls_link: next_state = st_wb;
					cls_load:          next_state = st_ld;
					cls_store:         next_state = st_st;
					default:           next_state = st_if; // branches, jumps
				endcase
			end
			st_ld:   if (mem_req_ready) next_state = st_rdw;
			st_rdw:  if (read_data_valid) next_state = st_wb;
			st_st:   if (mem_req_ready) next_state = st_if;
			st_wb:   next_state = st_if;
			default: next_state = st_init;
		endcase
	end

	// strobes straight from the state
	assign inst_req_valid  = (state == st_if);
	assign inst_ready      = (state == st_init) || (state == st_iw);
	assign mem_read        = (state == st_ld);
	assign mem_write       = (state == st_st);
	assign read_data_ready = (state == st_init) || (state == st_rdw);

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
		else $error("mem_read and mem_write both high");

	a_state_legal: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(state) && state <= st_wb)
		else $error("illegal fsm state");

endmodule

`default_nettype wire

// ==== hdl/mips_datapath.sv ====
`default_nettype none
`include "mips_macros.svh"

module mips_datapath import mips_pkg::*; (
	input  wire              clk,
	input  wire              rst,
	input  wire cpu_state_e  state,
	input  wire word_t       instruction,
	input  wire              inst_valid,
	input  wire word_t       read_data,
	input  wire a_src_e      a_src,
	input  wire b_src_e      b_src,
	input  wire alu_op_e     alu_op,
	input  wire wb_dest_e    wb_dest,
	input  wire inst_class_e inst_class,
	input  wire              branch_ne,
	input  wire word_t       rdata1,
	input  wire word_t       rdata2,
	input  wire word_t       alu_result,
	input  wire              alu_zero,
	output word_t            pc,
	output word_t            address,
	output word_t            write_data,
	output word_t            instr,
	output reg_addr_t        raddr1,
	output reg_addr_t        raddr2,
	output reg_addr_t        waddr,
	output logic             rf_wen,
	output word_t            wdata,
	output word_t            alu_a,
	output word_t            alu_b,
	output alu_op_e          alu_op_out,
	output word_t            retire_pc
);

	word_t rs_q, rt_q;  // operands latched in decode
	word_t res_q;       // branch target, then alu result
	word_t mdr_q;
	word_t sext_imm, zext_imm, jtarget;
	logic  capture, take;

	assign capture  = (state == st_iw) && inst_valid;
	assign sext_imm = {{16{instr[15]}}, instr[15:0]};
	assign zext_imm = {16'h0000, instr[15:0]};
	assign jtarget  = {pc[`MIPS_DATA_W-1:28], instr[25:0], 2'b00};
	assign raddr1   = instr[25:21];
	assign raddr2   = instr[20:16];

	always_comb begin
		alu_a      = pc; // fetch wait: pc + step
		alu_b      = word_t'(`MIPS_PC_STEP);
		alu_op_out = alu_add;
		case (state)
			st_id: alu_b = {sext_imm[`MIPS_DATA_W-3:0], 2'b00}; // branch target
			st_ex: begin
				case (a_src)
					a_rs:    alu_a = rs_q;
					a_shamt: alu_a = word_t'(instr[10:6]);
					default: alu_a = pc;
				endcase
				case (b_src)
					b_rt:    alu_b = rt_q;
					b_sext:  alu_b = sext_imm;
					b_zext:  alu_b = zext_imm;
					default: alu_b = word_t'(`MIPS_PC_STEP);
				endcase
				alu_op_out = alu_op;
			end
			default: ;
		endcase
	end

	assign take = (inst_class == cls_branch && (alu_zero ^ branch_ne))
		|| inst_class == cls_jump || inst_class == cls_link;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (capture)
			pc <= alu_result;
		else if (state == st_ex && take)
			pc <= (inst_class == cls_branch) ? res_q : jtarget;
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			instr     <= instruction;
			retire_pc <= pc; // own pc, before the step
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_id) begin
			rs_q <= rdata1;
			rt_q <= rdata2;
		end
		if (state == st_id || state == st_ex)
			res_q <= alu_result;
		if (state == st_rdw)
			mdr_q <= read_data; // last cycle here carries valid data
	end

	assign address    = {res_q[`MIPS_DATA_W-1:2], 2'b00};
	assign write_data = rt_q;

	always_comb begin
		case (wb_dest)
			wb_rt:   waddr = instr[20:16];
			wb_ra:   waddr = reg_addr_t'(`MIPS_RA_REG);
			default: waddr = instr[15:11];
		endcase
	end

	assign rf_wen = (state == st_wb);
	assign wdata  = (inst_class == cls_load) ? mdr_q : res_q;

	a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("pc not word aligned");

endmodule

`default_nettype wire

// ==== hdl/mips_cpu.sv ====
`default_nettype none

module mips_cpu import mips_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	output wire             inst_req_valid,
	input  wire             inst_req_ready,
	output wire word_t      pc,
	input  wire word_t      instruction,
	input  wire             inst_valid,
	output wire             inst_ready,
	output wire word_t      address,
	output wire             mem_read,
	output wire             mem_write,
	output wire word_t      write_data,
	input  wire             mem_req_ready,
	input  wire word_t      read_data,
	input  wire             read_data_valid,
	output wire             read_data_ready,
	output wire             retire_valid,
	output wire reg_addr_t  retire_waddr,
	output wire word_t      retire_wdata,
	output wire word_t      retire_pc
);

	wire cpu_state_e  state;
	wire inst_class_e inst_class;
	wire alu_op_e     alu_op, alu_op_out;
	wire a_src_e      a_src;
	wire b_src_e      b_src;
	wire wb_dest_e    wb_dest;
	wire              branch_ne, alu_zero;
	wire word_t       instr, rdata1, rdata2, alu_a, alu_b, alu_result;
	wire reg_addr_t   raddr1, raddr2;

	mips_control_fsm i_fsm (
		.clk, .rst, .inst_class, .inst_req_ready, .inst_valid, .mem_req_ready,
		.read_data_valid, .state, .inst_req_valid, .inst_ready, .mem_read, .mem_write,
		.read_data_ready
	);

	mips_decoder i_dec (.instr, .inst_class, .alu_op, .a_src, .b_src, .wb_dest, .branch_ne);

	// retire port shares the register-file write nets
	mips_datapath i_dp (
		.clk, .rst, .state, .instruction, .inst_valid, .read_data, .a_src, .b_src, .alu_op,
		.wb_dest, .inst_class, .branch_ne, .rdata1, .rdata2, .alu_result, .alu_zero, .pc,
		.address, .write_data, .instr, .raddr1, .raddr2, .waddr(retire_waddr),
		.rf_wen(retire_valid), .wdata(retire_wdata), .alu_a, .alu_b, .alu_op_out, .retire_pc
	);

	mips_regfile i_rf (
		.clk, .raddr1, .raddr2, .waddr(retire_waddr), .wen(retire_valid),
		.wdata(retire_wdata), .rdata1, .rdata2
	);

	mips_alu i_alu (.a(alu_a), .b(alu_b), .op(alu_op_out), .result(alu_result), .zero(alu_zero));

endmodule

`default_nettype wire

// ==== verif/mips_mem_model.sv ====
`default_nettype none

module mips_mem_model import mips_pkg::*; (
	input  wire        clk,
	input  wire        inst_req_valid,
	output logic       inst_req_ready,
	input  wire word_t pc,
	output word_t      instruction,
	output logic       inst_valid,
	input  wire        inst_ready,
	input  wire word_t address,
	input  wire        mem_read,
	input  wire        mem_write,
	input  wire word_t write_data,
	output logic       mem_req_ready,
	output word_t      read_data,
	output logic       read_data_valid,
	input  wire        read_data_ready
);

	timeunit 1ns;
	timeprecision 100ps;

	word_t      rom [47];
	word_t      ram [16];
	integer     seed;
	int         delay [4];
	int         ch, idx;
	logic [3:0] want, ans;

	// channels: inst request, inst data, mem request, read data
	assign want = {read_data_ready, mem_read | mem_write, inst_ready, inst_req_valid};
	assign {read_data_valid, mem_req_ready, inst_valid, inst_req_ready} = ans;

	initial begin
		seed        = 22;
		ans         = '0;
		instruction = '0;
		read_data   = '0;
		for (idx = 0; idx < 16; idx++)
			ram[idx] = 32'hdada_0000 | word_t'(idx * 4); // low half is the byte address
		// program from address 0, six words per row; 'h24160bad marks words that must not run
		rom = '{
			'h24010005, 'h2402fffd, 'h00221821, 'h00222023, 'h0041282a, 'h0041302b,
			'h3c071234, 'h34e75678, 'h00e44024, 'h00e14826, 'h00245027, 'h00245825,
			'h00076100, 'h00026f02, 'h00027043, 'h24200007, 'h00017821, 'h2850fffe,
			'h2c31ffff, 'h3052ff0f, 'h3833ffff, 'hac070008, 'hac89000c, 'h00000000,
			'h8c140008, 'h8c95000c, 'h102f0002, 'h24160bad, 'h24160bad, 'h142f0001,
			'h24170001, 'h14220001, 'h24160bad, 'h10220001, 'h24180002, 'h08000026,
			'h24160bad, 'h24160bad, 'h0c00002a, 'h24160bad, 'h24160bad, 'h24160bad,
			'h27f90004, 'h00000000, 'h00000000, 'h0337d021, 'h0800002e // ends in a self jump
		};
	end

	// each answer comes 0 to 3 falling edges after its request goes up
	always @(negedge clk) begin
		for (ch = 0; ch < 4; ch++) begin
			if (!want[ch]) begin
				ans[ch]   = 1'b0;
				delay[ch] = {$random(seed)} % 4;
			end else if (delay[ch] == 0) begin
				ans[ch] = 1'b1;
			end else begin
				delay[ch] = delay[ch] - 1;
			end
		end
		instruction = rom[pc[7:2]]; // pc holds still while fetching
		read_data   = ram[address[5:2]];
	end

	always @(posedge clk) begin
		if (mem_write && mem_req_ready)
			ram[address[5:2]] <= write_data;
	end

endmodule

`default_nettype wire

// ==== verif/mips_cpu_tb.sv ====
`default_nettype none
`include "mips_macros.svh"

module mips_cpu_tb import mips_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic      clk = 1'b0;
	logic      rst = 1'b1;
	logic      inst_req_valid, inst_req_ready, inst_valid, inst_ready;
	logic      mem_read, mem_write, mem_req_ready, read_data_valid, read_data_ready;
	logic      retire_valid;
	word_t     pc, instruction, address, write_data, read_data, retire_wdata, retire_pc;
	reg_addr_t retire_waddr;
	logic [4:0] strobes;

	// expected events in order, a store keeps address in exp_a and data in exp_b
	bit        exp_store [$];
	reg_addr_t exp_reg [$];
	word_t     exp_a [$];
	word_t     exp_b [$];
	int        ev_idx = 0;
	int        cycles = 0;
	int        cycle_limit = 0;
	bit        fetch_seen = 1'b0;

	always #4 clk = ~clk;

	// in init only inst_ready and read_data_ready are up
	assign strobes = {inst_req_valid, inst_ready, mem_read, mem_write, read_data_ready};

	mips_cpu i_dut (
		.clk, .rst, .inst_req_valid, .inst_req_ready, .pc, .instruction, .inst_valid,
		.inst_ready, .address, .mem_read, .mem_write, .write_data, .mem_req_ready,
		.read_data, .read_data_valid, .read_data_ready, .retire_valid, .retire_waddr,
		.retire_wdata, .retire_pc
	);

	mips_mem_model i_mem (
		.clk, .inst_req_valid, .inst_req_ready, .pc, .instruction, .inst_valid, .inst_ready,
		.address, .mem_read, .mem_write, .write_data, .mem_req_ready, .read_data,
		.read_data_valid, .read_data_ready
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic add_retire(input reg_addr_t r, input word_t val, input word_t at_pc);
		exp_store.push_back(1'b0);
		exp_reg.push_back(r);
		exp_a.push_back(val);
		exp_b.push_back(at_pc);
	endtask

	task automatic add_store(input word_t addr, input word_t data);
		exp_store.push_back(1'b1);
		exp_reg.push_back('0);
		exp_a.push_back(addr);
		exp_b.push_back(data);
	endtask

	task automatic check_retire(input reg_addr_t waddr, input word_t wdata, input word_t at_pc);
		if (exp_store[ev_idx])
			abort_run($sformatf("Error at %0d ns: r%0d written by pc %h, store to %h expected",
				$time, waddr, at_pc, exp_a[ev_idx]));
		else if (waddr !== exp_reg[ev_idx] || wdata !== exp_a[ev_idx] || at_pc !== exp_b[ev_idx])
			abort_run($sformatf("Error at %0d ns: retire r%0d=%h pc %h, expected r%0d=%h pc %h",
				$time, waddr, wdata, at_pc, exp_reg[ev_idx], exp_a[ev_idx], exp_b[ev_idx]));
	endtask

	task automatic check_store(input word_t addr, input word_t data);
		if (!exp_store[ev_idx])
			abort_run($sformatf("Error at %0d ns: store of %h to %h, r%0d write expected",
				$time, data, addr, exp_reg[ev_idx]));
		else if (addr !== exp_a[ev_idx] || data !== exp_b[ev_idx])
			abort_run($sformatf("Error at %0d ns: store %h to %h, expected %h to %h",
				$time, data, addr, exp_b[ev_idx], exp_a[ev_idx]));
	endtask

	task automatic check_fetch_pc(input word_t fetch_pc);
		if (fetch_pc !== '0)
			abort_run($sformatf("Error at %0d ns: first fetch from pc %h, expected 00000000",
				$time, fetch_pc));
	endtask

	// timeout, quiet reset, strobes in init and first fetch address
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
			abort_run($sformatf("timeout after %0d cycles with %0d of %0d events seen",
				cycles, ev_idx, exp_store.size()));
		else if (rst && (retire_valid === 1'b1 || (mem_write === 1'b1 && mem_req_ready)))
			abort_run("a retire or a store happened while reset was asserted");
		else if (rst && cycles > 1 && strobes !== 5'b01001)
			abort_run($sformatf("Error at %0d ns: strobes %b in reset, expected 01001",
				$time, strobes));
		else if (!rst && !fetch_seen && inst_req_valid && inst_req_ready) begin
			check_fetch_pc(pc);
			fetch_seen = 1'b1;
		end
	end

	initial begin
		add_retire(5'd1, 32'h0000_0005, 32'h00);
		add_retire(5'd2, 32'hffff_fffd, 32'h04);
		add_retire(5'd3, 32'h0000_0002, 32'h08); // 5 + -3
		add_retire(5'd4, 32'h0000_0008, 32'h0c);
		add_retire(5'd5, 32'h0000_0001, 32'h10); // signed -3 < 5
		add_retire(5'd6, 32'h0000_0000, 32'h14); // unsigned compare fails
		add_retire(5'd7, 32'h1234_0000, 32'h18);
		add_retire(5'd7, 32'h1234_5678, 32'h1c);
		add_retire(5'd8, 32'h0000_0008, 32'h20);
		add_retire(5'd9, 32'h1234_567d, 32'h24);
		add_retire(5'd10, 32'hffff_fff2, 32'h28);
		add_retire(5'd11, 32'h0000_000d, 32'h2c);
		add_retire(5'd12, 32'h2345_6780, 32'h30);
		add_retire(5'd13, 32'h0000_000f, 32'h34);
		add_retire(5'd14, 32'hffff_fffe, 32'h38);
		add_retire(5'd0, 32'h0000_000c, 32'h3c);  // r0 write still retires
		add_retire(5'd15, 32'h0000_0005, 32'h40); // r0 reads back as zero
		add_retire(5'd16, 32'h0000_0001, 32'h44);
		add_retire(5'd17, 32'h0000_0001, 32'h48);
		add_retire(5'd18, 32'h0000_ff0d, 32'h4c);
		add_retire(5'd19, 32'h0000_fffa, 32'h50);
		add_store(32'h0000_0008, 32'h1234_5678);
		add_store(32'h0000_0014, 32'h1234_567d);
		add_retire(5'd20, 32'h1234_5678, 32'h60);
		add_retire(5'd21, 32'h1234_567d, 32'h64);
		add_retire(5'd23, 32'h0000_0001, 32'h78); // after beq taken, bne untaken
		add_retire(5'd24, 32'h0000_0002, 32'h88); // after bne taken, beq untaken
		add_retire(reg_addr_t'(`MIPS_RA_REG), 32'h98 + 2 * `MIPS_PC_STEP, 32'h98);
		add_retire(5'd25, 32'h0000_00a4, 32'ha8); // first retire at the jal target
		add_retire(5'd26, 32'h0000_00a5, 32'hb4);
		cycle_limit = 40 * exp_store.size();
		repeat (10) @(negedge clk);
		rst = 1'b0;
		while (ev_idx < exp_store.size()) begin
			@(posedge clk);
			if (retire_valid) begin
				check_retire(retire_waddr, retire_wdata, retire_pc);
				ev_idx++;
			end else if (mem_write && mem_req_ready) begin
				check_store(address, write_data);
				ev_idx++;
			end
		end
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mips_cpu.f ====
+incdir+hdl
hdl/mips_pkg.sv
hdl/mips_regfile.sv
hdl/mips_alu.sv
hdl/mips_decoder.sv
hdl/mips_control_fsm.sv
hdl/mips_datapath.sv
hdl/mips_cpu.sv
verif/mips_mem_model.sv
verif/mips_cpu_tb.sv
